// File: src/dllp_consts.svh
`ifndef DLLP_CONSTS_SVH
`define DLLP_CONSTS_SVH

// DLLP type bytes for VC 0
`define DLLP_TYPE_INITFC1_P     8'h40
`define DLLP_TYPE_INITFC1_NP    8'h50
`define DLLP_TYPE_INITFC1_CPL   8'h60
`define DLLP_TYPE_INITFC2_P     8'hC0
`define DLLP_TYPE_INITFC2_NP    8'hD0
`define DLLP_TYPE_INITFC2_CPL   8'hE0
`define DLLP_TYPE_UPDATEFC_P    8'h80
`define DLLP_TYPE_UPDATEFC_NP   8'h90
`define DLLP_TYPE_UPDATEFC_CPL  8'hA0
`define DLLP_TYPE_ACK           8'h00
`define DLLP_TYPE_NAK           8'h10

`define DLLP_SDP_TOKEN          16'hACF0  // Start of DLLP framing token
`define DLLP_CRC_SEED           16'hFFFF
`define DLLP_CRC_POLY           16'h100B
`define DLLP_HDR_SCALE          2'd2
`define DLLP_DATA_SCALE         2'd3

// Gap between bursts is far shorter than the real timer
`define DLLP_RESEND_CYCLES      48

`endif

// File: src/dllp_pkg.sv
package dllp_pkg;

    typedef logic [7:0]  hdr_credit_t;
    typedef logic [11:0] data_credit_t;
    typedef logic [11:0] seq_num_t;
    typedef logic [31:0] dllp_body_t;     // Type byte plus three payload bytes
    typedef logic [15:0] dllp_crc_t;
    typedef logic [15:0] sdp_token_t;

    typedef enum logic [1:0] {
        LINK_INACTIVE = 2'd0,
        LINK_INIT1    = 2'd1,
        LINK_INIT2    = 2'd2,
        LINK_ACTIVE   = 2'd3
    } link_state_e;

    // Order matches the order inside a burst
    typedef enum logic [2:0] {
        KIND_FC_P   = 3'd0,
        KIND_FC_NP  = 3'd1,
        KIND_FC_CPL = 3'd2,
        KIND_ACKNAK = 3'd3
    } dllp_kind_e;

    typedef struct packed {
        hdr_credit_t  hdr;
        data_credit_t data;
    } fc_credits_t;

    typedef struct packed {
        dllp_kind_e  kind;
        link_state_e phase;   // Link state that issued the item
    } sched_item_t;

    typedef struct packed {
        sched_item_t tag;
        dllp_body_t  body;
    } body_item_t;

    typedef struct packed {
        sched_item_t tag;
        dllp_body_t  body;
        dllp_crc_t   crc;
    } crc_item_t;

    typedef struct packed {
        dllp_crc_t  crc;
        dllp_body_t body;
        sdp_token_t token;
    } dllp_frame_t;

endpackage

// File: src/dllp_scheduler.sv
`timescale 1ns/1ns
`include "dllp_consts.svh"

module dllp_scheduler import dllp_pkg::*; (
    input  logic        sclk,
    input  logic        arst_n_i,
    input  link_state_e link_state_i,
    input  logic        stall_i,
    output logic        item_valid_o,
    output sched_item_t item_o
);

    localparam int WAIT_W = $clog2(`DLLP_RESEND_CYCLES);

    typedef enum logic [1:0] {
        S_IDLE,
        S_BURST,
        S_WAIT
    } sched_state_e;

    sched_state_e      state_q;
    link_state_e       phase_q;     // Phase the running burst belongs to
    logic [1:0]        pos_q;       // Position inside the burst
    logic [WAIT_W-1:0] wait_q;
    logic [1:0]        last_pos;
    logic              phase_change;
    logic              wait_done;

    assign phase_change = (link_state_i != phase_q);

    // Init bursts end on Cpl, active bursts on the Ack/Nak
    assign last_pos  = (phase_q == LINK_ACTIVE) ? 2'd3 : 2'd2;
    assign wait_done = (wait_q == WAIT_W'(`DLLP_RESEND_CYCLES - 1));

    always_ff @(posedge sclk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q      <= S_IDLE;
            phase_q      <= LINK_INACTIVE;
            pos_q        <= 2'd0;
            wait_q       <= '0;
            item_valid_o <= 1'b0;
            item_o       <= '0;
        end else if (!stall_i) begin
            if (phase_change) begin
                // Abandon the old burst and start the new one next cycle
                phase_q      <= link_state_i;
                state_q      <= (link_state_i == LINK_INACTIVE) ? S_IDLE : S_BURST;
                pos_q        <= 2'd0;
                wait_q       <= '0;
                item_valid_o <= 1'b0;
            end else begin
                case (state_q)
                    S_BURST: begin
                        item_valid_o <= 1'b1;
                        item_o.kind  <= dllp_kind_e'({1'b0, pos_q});
                        item_o.phase <= phase_q;
                        if (pos_q == last_pos) begin
                            state_q <= S_WAIT;
                            wait_q  <= '0;
                        end else begin
                            pos_q <= pos_q + 2'd1;
                        end
                    end
                    S_WAIT: begin
                        item_valid_o <= 1'b0;
                        if (wait_done) begin   // Resend interval over
                            state_q <= S_BURST;
                            pos_q   <= 2'd0;
                        end else begin
                            wait_q <= wait_q + 1'b1;
                        end
                    end
                    default: begin
                        item_valid_o <= 1'b0;   // Inactive link sends nothing
                    end
                endcase
            end
        end
    end

endmodule

// File: src/dllp_assembler.sv
`timescale 1ns/1ns
`include "dllp_consts.svh"

module dllp_assembler import dllp_pkg::*; (
    input  logic        sclk,
    input  logic        arst_n_i,
    input  logic        item_valid_i,
    input  sched_item_t item_i,
    input  logic        stall_i,
    input  fc_credits_t limit_p_i,
    input  fc_credits_t limit_np_i,
    input  fc_credits_t limit_cpl_i,
    input  fc_credits_t used_p_i,
    input  fc_credits_t used_np_i,
    input  fc_credits_t used_cpl_i,
    input  logic        nak_sched_i,
    input  seq_num_t    next_rcv_seq_i,
    output logic        body_valid_o,
    output body_item_t  body_o
);

    logic        is_update;
    logic [7:0]  code_p;
    logic [7:0]  code_np;
    logic [7:0]  code_cpl;
    logic [7:0]  type_code;
    fc_credits_t fc_sel;
    dllp_body_t  body_d;

    assign is_update = (item_i.phase == LINK_ACTIVE);

    always_comb begin
        case (item_i.phase)
            LINK_INIT2: begin
                code_p   = `DLLP_TYPE_INITFC2_P;
                code_np  = `DLLP_TYPE_INITFC2_NP;
                code_cpl = `DLLP_TYPE_INITFC2_CPL;
            end
            LINK_ACTIVE: begin
                code_p   = `DLLP_TYPE_UPDATEFC_P;
                code_np  = `DLLP_TYPE_UPDATEFC_NP;
                code_cpl = `DLLP_TYPE_UPDATEFC_CPL;
            end
            default: begin
                code_p   = `DLLP_TYPE_INITFC1_P;
                code_np  = `DLLP_TYPE_INITFC1_NP;
                code_cpl = `DLLP_TYPE_INITFC1_CPL;
            end
        endcase

        // Init advertises limits, UpdateFC reports what was consumed
        case (item_i.kind)
            KIND_FC_NP: begin
                fc_sel    = is_update ? used_np_i : limit_np_i;
                type_code = code_np;
            end
            KIND_FC_CPL: begin
                fc_sel    = is_update ? used_cpl_i : limit_cpl_i;
                type_code = code_cpl;
            end
            default: begin
                fc_sel    = is_update ? used_p_i : limit_p_i;
                type_code = code_p;
            end
        endcase

        if (item_i.kind == KIND_ACKNAK)
            body_d = {nak_sched_i ? `DLLP_TYPE_NAK : `DLLP_TYPE_ACK, 12'd0, next_rcv_seq_i};
        else
            body_d = {type_code, `DLLP_HDR_SCALE, fc_sel.hdr, `DLLP_DATA_SCALE, fc_sel.data};
    end

    always_ff @(posedge sclk or negedge arst_n_i) begin
        if (!arst_n_i)
            body_valid_o <= 1'b0;
        else if (!stall_i)
            body_valid_o <= item_valid_i;
    end

    always_ff @(posedge sclk) begin
        if (!stall_i) begin
            body_o.tag  <= item_i;
            body_o.body <= body_d;
        end
    end

endmodule

// File: src/dllp_crc_stage.sv
`timescale 1ns/1ns
`include "dllp_consts.svh"

module dllp_crc_stage import dllp_pkg::*; (
    input  logic       sclk,
    input  logic       arst_n_i,
    input  logic       body_valid_i,
    input  body_item_t body_i,
    input  logic       stall_i,
    output logic       crc_valid_o,
    output crc_item_t  crc_item_o
);

    // Serial CRC-16 unrolled over the body, MSB first
    function automatic dllp_crc_t dllp_crc16(input dllp_body_t body);
        dllp_crc_t crc;
        crc = `DLLP_CRC_SEED;
        for (int i = 31; i >= 0; i--) begin
            if (crc[15] ^ body[i])
                crc = {crc[14:0], 1'b0} ^ `DLLP_CRC_POLY;
            else
                crc = {crc[14:0], 1'b0};
        end
        return ~crc;   // Sent inverted
    endfunction

    dllp_crc_t crc_d;

    assign crc_d = dllp_crc16(body_i.body);

    always_ff @(posedge sclk or negedge arst_n_i) begin
        if (!arst_n_i)
            crc_valid_o <= 1'b0;
        else if (!stall_i)
            crc_valid_o <= body_valid_i;
    end

    always_ff @(posedge sclk) begin
        if (!stall_i) begin
            crc_item_o.tag  <= body_i.tag;
            crc_item_o.body <= body_i.body;
            crc_item_o.crc  <= crc_d;
        end
    end

endmodule

// File: src/dllp_framer.sv
`timescale 1ns/1ns
`include "dllp_consts.svh"

module dllp_framer import dllp_pkg::*; (
    input  logic        sclk,
    input  logic        arst_n_i,
    input  logic        crc_valid_i,
    input  crc_item_t   crc_item_i,
    input  logic        stall_i,
    output logic        dllp_valid_o,
    output dllp_frame_t dllp_frame_o,
    output link_state_e frame_phase_o,
    output logic        frame_last_o
);

    logic last_d;

    // Burst ends on Ack/Nak when active, on the Cpl DLLP otherwise
    assign last_d = (crc_item_i.tag.phase == LINK_ACTIVE) ? (crc_item_i.tag.kind == KIND_ACKNAK)
                                                          : (crc_item_i.tag.kind == KIND_FC_CPL);

    always_ff @(posedge sclk or negedge arst_n_i) begin
        if (!arst_n_i)
            dllp_valid_o <= 1'b0;
        else if (!stall_i)
            dllp_valid_o <= crc_valid_i;   // Held while the buffer stalls
    end

    always_ff @(posedge sclk) begin
        if (!stall_i) begin
            dllp_frame_o  <= {crc_item_i.crc, crc_item_i.body, `DLLP_SDP_TOKEN};
            frame_phase_o <= crc_item_i.tag.phase;
            frame_last_o  <= last_d;
        end
    end

endmodule

// File: src/dllp_tx_top.sv
`timescale 1ns/1ns

module dllp_tx_top import dllp_pkg::*; #(
    parameter fc_credits_t CREDIT_LIMIT_P   = '{hdr: 8'd4, data: 12'd4},
    parameter fc_credits_t CREDIT_LIMIT_NP  = '{hdr: 8'd4, data: 12'd4},
    parameter fc_credits_t CREDIT_LIMIT_CPL = '{hdr: 8'd4, data: 12'd4}
) (
    input  logic        sclk,
    input  logic        arst_n_i,
    input  link_state_e link_state_i,
    input  fc_credits_t used_p_i,
    input  fc_credits_t used_np_i,
    input  fc_credits_t used_cpl_i,
    input  logic        nak_sched_i,
    input  seq_num_t    next_rcv_seq_i,
    input  logic        dllp_ready_i,
    output logic        dllp_valid_o,
    output dllp_frame_t dllp_frame_o,
    output logic        init1_sent_o,
    output logic        init2_sent_o
);

    logic        stall;        // Freezes every stage at once
    logic        item_valid;
    sched_item_t item;
    logic        body_valid;
    body_item_t  body;
    logic        crc_valid;
    crc_item_t   crc_item;
    link_state_e frame_phase;
    logic        frame_last;
    logic        burst_done;

    assign stall      = dllp_valid_o & ~dllp_ready_i;
    assign burst_done = dllp_valid_o & dllp_ready_i & frame_last;   // Last DLLP accepted

    dllp_scheduler u_scheduler (
        .sclk         (sclk),
        .arst_n_i     (arst_n_i),
        .link_state_i (link_state_i),
        .stall_i      (stall),
        .item_valid_o (item_valid),
        .item_o       (item)
    );

    dllp_assembler u_assembler (
        .sclk           (sclk),
        .arst_n_i       (arst_n_i),
        .item_valid_i   (item_valid),
        .item_i         (item),
        .stall_i        (stall),
        .limit_p_i      (CREDIT_LIMIT_P),
        .limit_np_i     (CREDIT_LIMIT_NP),
        .limit_cpl_i    (CREDIT_LIMIT_CPL),
        .used_p_i       (used_p_i),
        .used_np_i      (used_np_i),
        .used_cpl_i     (used_cpl_i),
        .nak_sched_i    (nak_sched_i),
        .next_rcv_seq_i (next_rcv_seq_i),
        .body_valid_o   (body_valid),
        .body_o         (body)
    );

    dllp_crc_stage u_crc_stage (
        .sclk         (sclk),
        .arst_n_i     (arst_n_i),
        .body_valid_i (body_valid),
        .body_i       (body),
        .stall_i      (stall),
        .crc_valid_o  (crc_valid),
        .crc_item_o   (crc_item)
    );

    dllp_framer u_framer (
        .sclk          (sclk),
        .arst_n_i      (arst_n_i),
        .crc_valid_i   (crc_valid),
        .crc_item_i    (crc_item),
        .stall_i       (stall),
        .dllp_valid_o  (dllp_valid_o),
        .dllp_frame_o  (dllp_frame_o),
        .frame_phase_o (frame_phase),
        .frame_last_o  (frame_last)
    );

    // Sent flags drop as soon as the link leaves their phase
    always_ff @(posedge sclk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            init1_sent_o <= 1'b0;
            init2_sent_o <= 1'b0;
        end else begin
            if (link_state_i != LINK_INIT1)
                init1_sent_o <= 1'b0;
            else if (burst_done && frame_phase == LINK_INIT1)
                init1_sent_o <= 1'b1;

            if (link_state_i != LINK_INIT2)
                init2_sent_o <= 1'b0;
            else if (burst_done && frame_phase == LINK_INIT2)
                init2_sent_o <= 1'b1;
        end
    end

endmodule

// File: bench/dllp_tx_properties.sv
`timescale 1ns/1ns

module dllp_tx_properties import dllp_pkg::*; (
    input logic        sclk,
    input logic        arst_n_i,
    input link_state_e link_state_i,
    input logic        dllp_ready_i,
    input logic        dllp_valid_o,
    input dllp_frame_t dllp_frame_o,
    input logic        init1_sent_o,
    input logic        init2_sent_o
);

    // Output held while the buffer back-pressures
    a_stream_stable: assert property (@(posedge sclk) disable iff (!arst_n_i)
        dllp_valid_o && !dllp_ready_i |=> dllp_valid_o && $stable(dllp_frame_o))
        else $error("Output stream changed while stalled");

    a_flags_inactive: assert property (@(posedge sclk) disable iff (!arst_n_i)
        link_state_i == LINK_INACTIVE |=> !init1_sent_o && !init2_sent_o)
        else $error("Sent flag high on an inactive link");

    // A flag may only drop after the link left its phase
    a_init1_hold: assert property (@(posedge sclk) disable iff (!arst_n_i)
        $fell(init1_sent_o) |-> $past(link_state_i) != LINK_INIT1)
        else $error("init1_sent_o fell inside init1");

    a_init2_hold: assert property (@(posedge sclk) disable iff (!arst_n_i)
        $fell(init2_sent_o) |-> $past(link_state_i) != LINK_INIT2)
        else $error("init2_sent_o fell inside init2");

endmodule

bind dllp_tx_top dllp_tx_properties u_properties (.*);

// File: bench/dllp_tx_tb.sv
`timescale 1ns/1ns
`include "dllp_consts.svh"

module dllp_tx_tb import dllp_pkg::*; ;

    logic        sclk;
    logic        arst_n_i;
    link_state_e link_state_i;
    fc_credits_t used_p_i;
    fc_credits_t used_np_i;
    fc_credits_t used_cpl_i;
    logic        nak_sched_i;
    seq_num_t    next_rcv_seq_i;
    logic        dllp_ready_i;
    logic        dllp_valid_o;
    dllp_frame_t dllp_frame_o;
    logic        init1_sent_o;
    logic        init2_sent_o;

    link_state_e ph_state[$];
    fc_credits_t ph_used_p[$];
    fc_credits_t ph_used_np[$];
    fc_credits_t ph_used_cpl[$];
    logic        ph_nak[$];
    seq_num_t    ph_seq[$];
    int          ph_count[$];
    dllp_body_t  exp_body[$];
    logic [31:0] rng;
    bit          loaded = 1'b0;
    int          watchdog_cycles;

    dllp_tx_top dut (.*);

    always #10 sclk = ~sclk;

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // CRC-16 over the body, MSB first, result inverted
    function automatic dllp_crc_t calc_crc(input dllp_body_t b);
        dllp_crc_t r;
        logic      fb;
        r = `DLLP_CRC_SEED;
        for (int i = 0; i < 32; i++) begin
            fb = r[15] ^ b[31-i];
            r  = r << 1;
            if (fb)
                r = r ^ `DLLP_CRC_POLY;
        end
        return ~r;
    endfunction

    task automatic check_value(input string name, input logic [63:0] got, input logic [63:0] exp);
        if (got !== exp) begin
            $display("Fail at %0t ns: %s got %h expected %h", $time, name, got, exp);
            $display("FAIL: see errors above");
            $fatal(1, "Mismatch on %s", name);
        end
    endtask

    task automatic load_trace();
        int          fd;
        int          n;
        int          total;
        string       line;
        logic [31:0] st, uph, upd, unh, und, uch, ucd, nak, seq, b;
        int          cnt;
        fd = $fopen("bench/dllp_tx_trace.txt", "r");
        if (fd == 0) begin
            $display("Cannot open the trace file bench/dllp_tx_trace.txt");
            $display("FAIL: see errors above");
            $fatal(1, "Trace missing");
        end
        total = 0;
        while (!$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            if (n == 0 || line.len() < 2 || line[0] == 8'h23)
                continue;   // Blank or comment line
            if ($sscanf(line, "phase %h %h %h %h %h %h %h %h %h %d",
                        st, uph, upd, unh, und, uch, ucd, nak, seq, cnt) == 10) begin
                ph_state.push_back(link_state_e'(st[1:0]));
                ph_used_p.push_back({uph[7:0], upd[11:0]});
                ph_used_np.push_back({unh[7:0], und[11:0]});
                ph_used_cpl.push_back({uch[7:0], ucd[11:0]});
                ph_nak.push_back(nak[0]);
                ph_seq.push_back(seq[11:0]);
                ph_count.push_back(cnt);
                total += cnt;
            end else if ($sscanf(line, "frame %h", b) == 1) begin
                exp_body.push_back(b);
            end else begin
                $display("Malformed trace line: %s", line);
                $display("FAIL: see errors above");
                $fatal(1, "Bad trace");
            end
        end
        $fclose(fd);
        if (total != exp_body.size()) begin
            $display("Trace frame counts do not match the number of frame lines");
            $display("FAIL: see errors above");
            $fatal(1, "Bad trace");
        end
        watchdog_cycles = (total + ph_state.size()) * (`DLLP_RESEND_CYCLES + 20);
    endtask

    // Inactive phases run a fixed time, the others until all frames are seen
    task automatic run_phase(input int p, input int base);
        int          got_n;
        int          cyc;
        dllp_body_t  b;
        logic [63:0] exp_frame;
        got_n = 0;
        cyc   = 0;
        @(posedge sclk);
        link_state_i   <= ph_state[p];
        used_p_i       <= ph_used_p[p];
        used_np_i      <= ph_used_np[p];
        used_cpl_i     <= ph_used_cpl[p];
        nak_sched_i    <= ph_nak[p];
        next_rcv_seq_i <= ph_seq[p];
        while ((ph_count[p] == 0) ? (cyc < 30) : (got_n < ph_count[p])) begin
            @(negedge sclk);
            if (cyc > 0) begin   // Flags follow the link one edge late
                check_value("init1_sent_o", 64'(init1_sent_o),
                            64'(ph_state[p] == LINK_INIT1 && got_n >= 3));
                check_value("init2_sent_o", 64'(init2_sent_o),
                            64'(ph_state[p] == LINK_INIT2 && got_n >= 3));
            end
            if (p == 0)
                check_value("dllp_valid_o", 64'(dllp_valid_o), 64'd0);
            // Frames left over from the previous phase are skipped
            if (dllp_valid_o && dllp_ready_i && ph_count[p] > 0
                    && dut.frame_phase == ph_state[p]) begin
                b         = exp_body[base + got_n];
                exp_frame = {calc_crc(b), b, `DLLP_SDP_TOKEN};
                check_value("dllp_frame_o", dllp_frame_o, exp_frame);
                got_n++;
            end
            cyc++;
        end
    endtask

    always @(posedge sclk) begin
        rng = lcg_next(rng);
        dllp_ready_i <= (rng[31:30] != 2'b00);   // Ready about three cycles in four
    end

    initial begin
        int base;
        sclk           = 1'b0;
        arst_n_i       = 1'b0;
        link_state_i   = LINK_INACTIVE;
        used_p_i       = '0;
        used_np_i      = '0;
        used_cpl_i     = '0;
        nak_sched_i    = 1'b0;
        next_rcv_seq_i = '0;
        dllp_ready_i   = 1'b0;
        rng            = 32'hd271cd9a;
        load_trace();
        loaded = 1'b1;
        repeat (3) @(posedge sclk);
        arst_n_i <= 1'b1;
        base = 0;
        for (int p = 0; p < ph_state.size(); p++) begin
            run_phase(p, base);
            base += ph_count[p];
        end
        $display("PASS: all tests");
        $finish;
    end

    initial begin
        wait (loaded);
        repeat (watchdog_cycles) @(posedge sclk);
        $display("Timeout: expected frames did not arrive within %0d cycles", watchdog_cycles);
        $display("FAIL: see errors above");
        $fatal(1, "Watchdog expired");
    end

endmodule

// File: bench/dllp_tx_trace.txt
# phase <state> <p_hdr> <p_data> <np_hdr> <np_data> <cpl_hdr> <cpl_data> <nak> <seq> <count>
# frame <dllp body, hex>  (expected frames of the phase above, in order)
phase 0 00 000 00 000 00 000 0 000 0
phase 1 00 000 00 000 00 000 0 000 6
frame 40813004
frame 50813004
frame 60813004
frame 40813004
frame 50813004
frame 60813004
phase 2 00 000 00 000 00 000 0 000 6
frame C0813004
frame D0813004
frame E0813004
frame C0813004
frame D0813004
frame E0813004
phase 3 12 345 06 000 A5 FFF 0 123 8
frame 8084B345
frame 9081B000
frame A0A97FFF
frame 00000123
frame 8084B345
frame 9081B000
frame A0A97FFF
frame 00000123
phase 0 00 000 00 000 00 000 0 000 0
phase 3 01 001 FF 800 00 000 1 ABC 4
frame 80807001
frame 90BFF800
frame A0803000
frame 10000ABC

// File: sources.f
+incdir+src
src/dllp_pkg.sv
src/dllp_scheduler.sv
src/dllp_assembler.sv
src/dllp_crc_stage.sv
src/dllp_framer.sv
src/dllp_tx_top.sv
bench/dllp_tx_properties.sv
bench/dllp_tx_tb.sv

// File: Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module dllp_tx_tb -f sources.f -Mdir obj_dir
	./obj_dir/Vdllp_tx_tb

clean:
	rm -rf obj_dir
